//--- sources.f
common/ldst_pkg.sv
rtl/fwd_cache.sv
store_buffer/store_buffer.sv
rtl/load_unit.sv
rtl/wb_arbiter.sv
rtl/ldst_top.sv
verification/tb_clk_gen.sv
verification/tb_ldst.sv

//--- Makefile
# Verilator build and run for the load/store forwarding testbench

VERILATOR ?= verilator
TOP       ?= tb_ldst
BUILD_DIR ?= build
FILELIST  ?= sources.f
PASS_MSG  := TESTBENCH PASSED

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing -j 0 --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_ldst.sv
`timescale 1ns/1ps

module tb_ldst import ldst_pkg::*;;

  localparam int unsigned DEPTH = 4;

  typedef enum logic [1:0] {OP_STORE, OP_LOAD, OP_FLUSH, OP_IDLE} op_t;

  logic clk;
  logic rst_n;
  logic st_valid, st_ready, ld_valid, ld_ready, ld_done, ld_fwd;
  logic flush, st_idle, wb_cyc, wb_stb, wb_we;
  logic [XLEN-1:0] st_addr, st_value, ld_addr, ld_data, wb_adr, wb_dat_o;
  logic [WB_SEL_W-1:0] wb_sel;
  ldst_width_t st_width, ld_width;
  // bus slave outputs, owned by the memory model
  logic wb_ack = 1'b0;
  logic [XLEN-1:0] wb_rdata = '0;

  // stimulus table, one entry per row in each queue
  string row_name[$];
  op_t row_op[$];
  logic [XLEN-1:0] row_addr[$];
  ldst_width_t row_width[$];
  logic [XLEN-1:0] row_value[$];
  logic row_hold[$];
  logic [XLEN-1:0] row_exp_data[$];
  logic row_exp_fwd[$];

  logic hold_ack = 1'b0;
  integer seed = 32'hb952_3a9c;
  int unsigned cycle_cnt = 0;
  int unsigned timeout_cycles = 0;

  tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(5)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  ldst_top #(.STBUFF_DEPTH(DEPTH)) u_dut (
    .clk_i(clk), .rst_n_i(rst_n),
    .st_valid_i(st_valid), .st_ready_o(st_ready), .st_addr_i(st_addr),
    .st_width_i(st_width), .st_value_i(st_value),
    .ld_valid_i(ld_valid), .ld_ready_o(ld_ready), .ld_addr_i(ld_addr),
    .ld_width_i(ld_width), .ld_done_o(ld_done), .ld_data_o(ld_data), .ld_fwd_o(ld_fwd),
    .flush_i(flush), .st_idle_o(st_idle),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_sel_o(wb_sel), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_rdata), .wb_ack_i(wb_ack)
  );

  // ------------------------------------------------------------
  // wishbone slave memory, decides on the falling edge
  // ------------------------------------------------------------
  logic [XLEN-1:0] mem [256];
  logic [1:0] wait_left;
  logic ack_d;
  logic [XLEN-1:0] rdata_d;
  logic [31:0] rnd;

  always @(negedge clk) begin
    if (!rst_n) begin
      // fill depends on the byte address of each word
      for (int i = 0; i < 256; i++) mem[i] = 32'ha5a5_0000 ^ (32'(i) << 2);
      ack_d = 1'b0;
      rdata_d = '0;
      wait_left = 2'd1;
    end else if (wb_cyc && wb_stb) begin
      if (wb_ack) begin
        // transfer completes on the coming edge
        for (int b = 0; b < WB_SEL_W; b++) begin
          if (wb_we && wb_sel[b]) mem[wb_adr[9:2]][8*b +: 8] = wb_dat_o[8*b +: 8];
        end
        ack_d = 1'b0;
        rnd = $random(seed);
        wait_left = rnd[1:0];
      end else if (!hold_ack && wait_left == 2'd0) begin
        ack_d = 1'b1;
        rdata_d = mem[wb_adr[9:2]];
      end else if (!hold_ack) begin
        wait_left = wait_left - 1'b1;
      end
    end else begin
      ack_d = 1'b0;
    end
  end

  // slave outputs change just after the rising edge
  always @(posedge clk) begin
    #1;
    wb_ack = ack_d;
    wb_rdata = rdata_d;
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (exp !== act) abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_fwd(input string name, input logic exp, input logic act);
    if (exp !== act) abort_run($sformatf("mismatch %s fwd: expected %b, actual %b", name, exp, act));
  endtask

  // status outputs such as ready and idle
  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) abort_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
  endtask

  // ------------------------------------------------------------
  // row drivers, each starts and ends 1 ns after a rising edge
  // ------------------------------------------------------------
  task automatic add_row(input string name, input op_t op, input logic [XLEN-1:0] addr,
                         input ldst_width_t w, input logic [XLEN-1:0] value, input logic hold,
                         input logic [XLEN-1:0] exp_data, input logic exp_fwd);
    row_name.push_back(name);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_width.push_back(w);
    row_value.push_back(value);
    row_hold.push_back(hold);
    row_exp_data.push_back(exp_data);
    row_exp_fwd.push_back(exp_fwd);
  endtask

  task automatic drive_store(input logic [XLEN-1:0] addr, input ldst_width_t w,
                             input logic [XLEN-1:0] value);
    st_valid = 1'b1;
    st_addr = addr;
    st_width = w;
    st_value = value;
    @(negedge clk);
    while (!st_ready) @(negedge clk);
    @(posedge clk);
    #1 st_valid = 1'b0;
  endtask

  task automatic run_load(input string name, input logic [XLEN-1:0] addr, input ldst_width_t w,
                          input logic [XLEN-1:0] exp_data, input logic exp_fwd);
    int unsigned lat;
    ld_valid = 1'b1;
    ld_addr = addr;
    ld_width = w;
    @(negedge clk);
    while (!ld_ready) @(negedge clk);
    @(posedge clk);
    #1 ld_valid = 1'b0;
    // cycles from acceptance to the done pulse
    lat = 1;
    @(negedge clk);
    while (!ld_done) begin
      @(negedge clk);
      lat++;
    end
    check_data(name, exp_data, ld_data);
    check_fwd(name, exp_fwd, ld_fwd);
    if (exp_fwd && lat != 1) begin
      abort_run($sformatf("%s: forwarded load took %0d cycles instead of 1", name, lat));
    end
    @(posedge clk);
    #1;
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(posedge clk);
    #1 flush = 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (!st_idle) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic build_table();
    // forward hits under hold
    add_row("fwd word st", OP_STORE, 32'h200, LDST_WORD, 32'h1357_9bdf, 1'b1, '0, 1'b0);
    add_row("fwd byte st", OP_STORE, 32'h205, LDST_BYTE, 32'hffff_ff5a, 1'b1, '0, 1'b0);
    add_row("fwd word ld", OP_LOAD, 32'h200, LDST_WORD, '0, 1'b1, 32'h1357_9bdf, 1'b1);
    add_row("fwd byte ld", OP_LOAD, 32'h205, LDST_BYTE, '0, 1'b1, 32'h0000_005a, 1'b1);
    add_row("fwd release", OP_IDLE, '0, LDST_WORD, '0, 1'b0, '0, 1'b0);
    // lanes and zero extension through memory
    add_row("lane word st", OP_STORE, 32'h300, LDST_WORD, 32'h8899_aabb, 1'b0, '0, 1'b0);
    add_row("lane word idle", OP_IDLE, '0, LDST_WORD, '0, 1'b0, '0, 1'b0);
    add_row("lane word ld", OP_LOAD, 32'h300, LDST_WORD, '0, 1'b0, 32'h8899_aabb, 1'b0);
    add_row("lane byte st", OP_STORE, 32'h301, LDST_BYTE, 32'hffff_ffc3, 1'b0, '0, 1'b0);
    add_row("lane byte idle", OP_IDLE, '0, LDST_WORD, '0, 1'b0, '0, 1'b0);
    add_row("lane byte ld", OP_LOAD, 32'h301, LDST_BYTE, '0, 1'b0, 32'h0000_00c3, 1'b0);
    add_row("lane merge ld", OP_LOAD, 32'h300, LDST_WORD, '0, 1'b0, 32'h8899_c3bb, 1'b0);
    add_row("lane half st", OP_STORE, 32'h302, LDST_HALF, 32'h1234_5678, 1'b0, '0, 1'b0);
    add_row("lane half idle", OP_IDLE, '0, LDST_WORD, '0, 1'b0, '0, 1'b0);
    add_row("lane half ld", OP_LOAD, 32'h302, LDST_HALF, '0, 1'b0, 32'h0000_5678, 1'b0);
    add_row("lane top ld", OP_LOAD, 32'h303, LDST_BYTE, '0, 1'b0, 32'h0000_0056, 1'b0);
    // width mismatch and reserved low region never forward
    add_row("width st", OP_STORE, 32'h120, LDST_WORD, 32'hcafe_f00d, 1'b1, '0, 1'b0);
    add_row("width ld", OP_LOAD, 32'h120, LDST_HALF, '0, 1'b0, 32'h0000_f00d, 1'b0);
    add_row("low st", OP_STORE, 32'h040, LDST_WORD, 32'h0bad_beef, 1'b1, '0, 1'b0);
    add_row("low ld", OP_LOAD, 32'h040, LDST_WORD, '0, 1'b0, 32'h0bad_beef, 1'b0);
    // flush drops the slot, the store still drains
    add_row("flush st", OP_STORE, 32'h220, LDST_WORD, 32'h2468_ace0, 1'b1, '0, 1'b0);
    add_row("flush", OP_FLUSH, '0, LDST_WORD, '0, 1'b1, '0, 1'b0);
    add_row("flush ld", OP_LOAD, 32'h220, LDST_WORD, '0, 1'b0, 32'h2468_ace0, 1'b0);
    // full buffer, drain order shows in the merged word
    add_row("full st0", OP_STORE, 32'h340, LDST_WORD, 32'h0102_0304, 1'b1, '0, 1'b0);
    add_row("full st1", OP_STORE, 32'h340, LDST_BYTE, 32'h0000_00ee, 1'b1, '0, 1'b0);
    add_row("full st2", OP_STORE, 32'h342, LDST_HALF, 32'hffff_abcd, 1'b1, '0, 1'b0);
    add_row("full st3", OP_STORE, 32'h344, LDST_WORD, 32'h5555_aaaa, 1'b1, '0, 1'b0);
    add_row("full fwd ld", OP_LOAD, 32'h344, LDST_WORD, '0, 1'b1, 32'h5555_aaaa, 1'b1);
    add_row("full drain", OP_IDLE, '0, LDST_WORD, '0, 1'b0, '0, 1'b0);
    add_row("full ld0", OP_LOAD, 32'h340, LDST_WORD, '0, 1'b0, 32'habcd_03ee, 1'b0);
    add_row("full ld1", OP_LOAD, 32'h344, LDST_WORD, '0, 1'b0, 32'h5555_aaaa, 1'b0);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    int unsigned held_count;
    st_valid = 1'b0;
    st_addr = '0;
    st_width = LDST_WORD;
    st_value = '0;
    ld_valid = 1'b0;
    ld_addr = '0;
    ld_width = LDST_WORD;
    flush = 1'b0;
    held_count = 0;
    build_table();
    // worst row is a miss load behind a full drain
    timeout_cycles = row_name.size() * 40;
    @(posedge rst_n);
    @(negedge clk);
    check_flag("reset st_ready", 1'b1, st_ready);
    check_flag("reset ld_ready", 1'b1, ld_ready);
    check_flag("reset st_idle", 1'b1, st_idle);
    check_flag("reset wb_cyc", 1'b0, wb_cyc);
    check_flag("reset wb_stb", 1'b0, wb_stb);
    check_flag("reset ld_done", 1'b0, ld_done);
    @(posedge clk);
    #1;
    for (int r = 0; r < row_name.size(); r++) begin
      hold_ack = row_hold[r];
      if (!hold_ack) held_count = 0;
      case (row_op[r])
        OP_STORE: begin
          drive_store(row_addr[r], row_width[r], row_value[r]);
          if (hold_ack) begin
            // held stores stay buffered, ready drops at full
            held_count++;
            @(negedge clk);
            check_flag({row_name[r], " st_ready"}, held_count < DEPTH, st_ready);
            @(posedge clk);
            #1;
          end
        end
        OP_LOAD: run_load(row_name[r], row_addr[r], row_width[r], row_exp_data[r],
                          row_exp_fwd[r]);
        OP_FLUSH: pulse_flush();
        default: wait_idle();
      endcase
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

  // run limit
  initial begin
    @(posedge rst_n);
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    abort_run($sformatf("timeout: run did not finish within %0d cycles", timeout_cycles));
  end

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release just after a rising edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- rtl/ldst_top.sv
`timescale 1ns/1ps

module ldst_top import ldst_pkg::*; #(
  parameter int unsigned STBUFF_DEPTH = 4,
  localparam int unsigned StIdxW = $clog2(STBUFF_DEPTH),
  localparam int unsigned TagW = XLEN - StIdxW
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // store port
  input  logic                st_valid_i,
  output logic                st_ready_o,
  input  logic [XLEN-1:0]     st_addr_i,
  input  ldst_width_t         st_width_i,
  input  logic [XLEN-1:0]     st_value_i,
  // load port
  input  logic                ld_valid_i,
  output logic                ld_ready_o,
  input  logic [XLEN-1:0]     ld_addr_i,
  input  ldst_width_t         ld_width_i,
  output logic                ld_done_o,
  output logic [XLEN-1:0]     ld_data_o,
  output logic                ld_fwd_o,
  // control
  input  logic                flush_i,
  output logic                st_idle_o,
  // wishbone master
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic                wb_we_o,
  output logic [XLEN-1:0]     wb_adr_o,
  output logic [WB_SEL_W-1:0] wb_sel_o,
  output logic [XLEN-1:0]     wb_dat_o,
  input  logic [XLEN-1:0]     wb_dat_i,
  input  logic                wb_ack_i
);

  // ------------------------------------------------------------
  // internal wires
  // ------------------------------------------------------------
  // cache update from the store buffer
  logic              upd;
  logic [XLEN-1:0]   upd_addr;
  logic [StIdxW-1:0] upd_idx;
  // entry lookup
  logic [StIdxW-1:0] ent_idx;
  logic              ent_live;
  ldst_width_t       ent_width;
  logic [TagW-1:0]   ent_tag;
  logic [XLEN-1:0]   ent_value;
  // forwarding result
  logic [XLEN-1:0]   look_addr;
  logic              fwd_hit;
  logic [XLEN-1:0]   fwd_value;
  logic              sb_empty;
  // load unit master
  logic                lu_cyc;
  logic                lu_stb;
  logic [XLEN-1:0]     lu_adr;
  logic [WB_SEL_W-1:0] lu_sel;
  logic                lu_ack;
  logic [XLEN-1:0]     lu_dat;
  // store buffer master
  logic                sb_cyc;
  logic                sb_stb;
  logic                sb_we;
  logic [XLEN-1:0]     sb_adr;
  logic [WB_SEL_W-1:0] sb_sel;
  logic [XLEN-1:0]     sb_dat;
  logic                sb_ack;

  assign st_idle_o = sb_empty;

  store_buffer #(.STBUFF_DEPTH(STBUFF_DEPTH)) u_store_buffer (
    .clk_i, .rst_n_i,
    .st_valid_i, .st_ready_o, .st_addr_i, .st_width_i, .st_value_i,
    .upd_o(upd), .upd_addr_o(upd_addr), .upd_idx_o(upd_idx),
    .lk_idx_i(ent_idx), .lk_live_o(ent_live), .lk_width_o(ent_width),
    .lk_tag_o(ent_tag), .lk_value_o(ent_value),
    .empty_o(sb_empty), .wb_cyc_o(sb_cyc), .wb_stb_o(sb_stb), .wb_we_o(sb_we),
    .wb_adr_o(sb_adr), .wb_sel_o(sb_sel), .wb_dat_o(sb_dat), .wb_ack_i(sb_ack)
  );

  fwd_cache #(.STBUFF_DEPTH(STBUFF_DEPTH)) u_fwd_cache (
    .clk_i, .rst_n_i, .flush_i,
    .upd_i(upd), .upd_addr_i(upd_addr), .upd_idx_i(upd_idx),
    .ld_addr_i(look_addr), .ld_width_i(ld_width_i),
    .ent_live_i(ent_live), .ent_width_i(ent_width), .ent_tag_i(ent_tag),
    .ent_value_i(ent_value), .ent_idx_o(ent_idx),
    .hit_o(fwd_hit), .value_o(fwd_value)
  );

  load_unit #(.STBUFF_DEPTH(STBUFF_DEPTH)) u_load_unit (
    .clk_i, .rst_n_i,
    .ld_valid_i, .ld_ready_o, .ld_addr_i, .ld_width_i,
    .ld_done_o, .ld_data_o, .ld_fwd_o,
    .look_addr_o(look_addr), .hit_i(fwd_hit), .fwd_value_i(fwd_value),
    .sb_empty_i(sb_empty),
    .wb_cyc_o(lu_cyc), .wb_stb_o(lu_stb), .wb_adr_o(lu_adr), .wb_sel_o(lu_sel),
    .wb_dat_i(lu_dat), .wb_ack_i(lu_ack)
  );

  // load unit only reads, so its write enable and data are tied off
  wb_arbiter u_wb_arbiter (
    .clk_i, .rst_n_i,
    .m0_cyc_i(lu_cyc), .m0_stb_i(lu_stb), .m0_we_i(1'b0), .m0_adr_i(lu_adr),
    .m0_sel_i(lu_sel), .m0_dat_i('0), .m0_ack_o(lu_ack), .m0_dat_o(lu_dat),
    .m1_cyc_i(sb_cyc), .m1_stb_i(sb_stb), .m1_we_i(sb_we), .m1_adr_i(sb_adr),
    .m1_sel_i(sb_sel), .m1_dat_i(sb_dat), .m1_ack_o(sb_ack),
    .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_sel_o, .wb_dat_o,
    .wb_dat_i, .wb_ack_i
  );

endmodule

//--- rtl/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter import ldst_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // master 0, load unit
  input  logic                m0_cyc_i,
  input  logic                m0_stb_i,
  input  logic                m0_we_i,
  input  logic [XLEN-1:0]     m0_adr_i,
  input  logic [WB_SEL_W-1:0] m0_sel_i,
  input  logic [XLEN-1:0]     m0_dat_i,
  output logic                m0_ack_o,
  output logic [XLEN-1:0]     m0_dat_o,
  // master 1, store buffer drain
  input  logic                m1_cyc_i,
  input  logic                m1_stb_i,
  input  logic                m1_we_i,
  input  logic [XLEN-1:0]     m1_adr_i,
  input  logic [WB_SEL_W-1:0] m1_sel_i,
  input  logic [XLEN-1:0]     m1_dat_i,
  output logic                m1_ack_o,
  // external bus
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic                wb_we_o,
  output logic [XLEN-1:0]     wb_adr_o,
  output logic [WB_SEL_W-1:0] wb_sel_o,
  output logic [XLEN-1:0]     wb_dat_o,
  input  logic [XLEN-1:0]     wb_dat_i,
  input  logic                wb_ack_i
);

  // owner 0 is the load unit
  logic owner_q;
  logic owner;
  // open transfer not yet acknowledged
  logic busy_q;

  // keep the owner until its transfer is acknowledged
  assign owner = busy_q ? owner_q : (m0_cyc_i ? 1'b0 : (m1_cyc_i ? 1'b1 : owner_q));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owner_q <= 1'b0;
      busy_q  <= 1'b0;
    end else begin
      owner_q <= owner;
      // bus frees up in the ack cycle
      busy_q  <= wb_cyc_o && !wb_ack_i;
    end
  end

  // ------------------------------------------------------------
  // bus mux, only the owner drives
  // ------------------------------------------------------------
  assign wb_cyc_o = owner ? m1_cyc_i : m0_cyc_i;
  assign wb_stb_o = owner ? m1_stb_i : m0_stb_i;
  assign wb_we_o  = owner ? m1_we_i  : m0_we_i;
  assign wb_adr_o = owner ? m1_adr_i : m0_adr_i;
  assign wb_sel_o = owner ? m1_sel_i : m0_sel_i;
  assign wb_dat_o = owner ? m1_dat_i : m0_dat_i;

  // ack routed back to the owner only
  assign m0_ack_o = wb_ack_i && !owner;
  assign m1_ack_o = wb_ack_i && owner;
  assign m0_dat_o = wb_dat_i;

endmodule

//--- rtl/load_unit.sv
`timescale 1ns/1ps

module load_unit import ldst_pkg::*; #(
  parameter int unsigned STBUFF_DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // load port
  input  logic                ld_valid_i,
  output logic                ld_ready_o,
  input  logic [XLEN-1:0]     ld_addr_i,
  input  ldst_width_t         ld_width_i,
  output logic                ld_done_o,
  output logic [XLEN-1:0]     ld_data_o,
  output logic                ld_fwd_o,
  // forwarding cache lookup
  output logic [XLEN-1:0]     look_addr_o,
  input  logic                hit_i,
  input  logic [XLEN-1:0]     fwd_value_i,
  // store buffer state
  input  logic                sb_empty_i,
  // read master
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic [XLEN-1:0]     wb_adr_o,
  output logic [WB_SEL_W-1:0] wb_sel_o,
  input  logic [XLEN-1:0]     wb_dat_i,
  input  logic                wb_ack_i
);

  // ------------------------------------------------------------
  // load FSM
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    LU_IDLE  = 2'd0,
    LU_WAIT  = 2'd1,
    LU_BUS   = 2'd2,
    LU_DONE  = 2'd3
  } lu_state_t;

  lu_state_t       state_q;
  logic [XLEN-1:0] addr_q;
  ldst_width_t     width_q;
  logic [XLEN-1:0] data_q;
  logic            fwd_q;
  logic            accept;
  logic [XLEN-1:0] rd_shift;

  assign ld_ready_o = (state_q == LU_IDLE);
  assign accept     = ld_valid_i && ld_ready_o;

  // lookup uses the live input on acceptance, then the held address
  assign look_addr_o = (state_q == LU_IDLE) ? ld_addr_i : addr_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LU_IDLE;
    end else begin
      case (state_q)
        LU_IDLE: begin
          if (accept) state_q <= hit_i ? LU_DONE : LU_WAIT;
        end
        // older stores must reach memory first
        LU_WAIT: begin
          if (sb_empty_i) state_q <= LU_BUS;
        end
        LU_BUS: begin
          if (wb_ack_i) state_q <= LU_DONE;
        end
        default: state_q <= LU_IDLE;
      endcase
    end
  end

  // request and result registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= ld_addr_i;
      width_q <= ld_width_i;
      data_q  <= fwd_value_i;
      fwd_q   <= hit_i;
    end else if (state_q == LU_BUS && wb_ack_i) begin
      data_q <= ldst_zext(width_q, rd_shift);
      fwd_q  <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // bus read and lane extraction
  // ------------------------------------------------------------
  assign wb_cyc_o = (state_q == LU_BUS);
  assign wb_stb_o = (state_q == LU_BUS);
  assign wb_adr_o = {addr_q[XLEN-1:2], 2'b00};
  assign wb_sel_o = ldst_sel(width_q, addr_q[1:0]);
  // bring the addressed lanes down to bit 0
  assign rd_shift = wb_dat_i >> {addr_q[1:0], 3'b000};

  // one-cycle completion
  assign ld_done_o = (state_q == LU_DONE);
  assign ld_data_o = data_q;
  assign ld_fwd_o  = fwd_q;

endmodule

//--- store_buffer/store_buffer.sv
`timescale 1ns/1ps

module store_buffer import ldst_pkg::*; #(
  parameter int unsigned STBUFF_DEPTH = 4,
  localparam int unsigned StIdxW = $clog2(STBUFF_DEPTH),
  localparam int unsigned TagW = XLEN - StIdxW
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // store port
  input  logic                st_valid_i,
  output logic                st_ready_o,
  input  logic [XLEN-1:0]     st_addr_i,
  input  ldst_width_t         st_width_i,
  input  logic [XLEN-1:0]     st_value_i,
  // forwarding cache update
  output logic                upd_o,
  output logic [XLEN-1:0]     upd_addr_o,
  output logic [StIdxW-1:0]   upd_idx_o,
  // entry lookup
  input  logic [StIdxW-1:0]   lk_idx_i,
  output logic                lk_live_o,
  output ldst_width_t         lk_width_o,
  output logic [TagW-1:0]     lk_tag_o,
  output logic [XLEN-1:0]     lk_value_o,
  // drain master
  output logic                empty_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic                wb_we_o,
  output logic [XLEN-1:0]     wb_adr_o,
  output logic [WB_SEL_W-1:0] wb_sel_o,
  output logic [XLEN-1:0]     wb_dat_o,
  input  logic                wb_ack_i
);

  // ------------------------------------------------------------
  // queue storage
  // ------------------------------------------------------------
  logic [XLEN-1:0] q_addr  [STBUFF_DEPTH];
  ldst_width_t     q_width [STBUFF_DEPTH];
  logic [XLEN-1:0] q_value [STBUFF_DEPTH];
  // live means written but not yet acknowledged on the bus
  logic            q_live  [STBUFF_DEPTH];

  logic [StIdxW-1:0] head_q;
  logic [StIdxW-1:0] tail_q;
  logic [StIdxW:0]   count_q;

  logic push;
  logic pop;
  logic [1:0] head_off;
  logic [XLEN-1:0] lk_addr;

  assign st_ready_o = (count_q != STBUFF_DEPTH[StIdxW:0]);
  assign empty_o    = (count_q == '0);
  assign push       = st_valid_i && st_ready_o;
  // head leaves on the write ack
  assign pop        = wb_cyc_o && wb_ack_i;

  // pointers and count
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) tail_q <= tail_q + 1'b1;
      if (pop) head_q <= head_q + 1'b1;
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // live flags
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < STBUFF_DEPTH; i++) q_live[i] <= 1'b0;
    end else begin
      if (pop) q_live[head_q] <= 1'b0;
      if (push) q_live[tail_q] <= 1'b1;
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (push) begin
      q_addr[tail_q]  <= st_addr_i;
      q_width[tail_q] <= st_width_i;
      q_value[tail_q] <= st_value_i;
    end
  end

  // ------------------------------------------------------------
  // cache update and lookup
  // ------------------------------------------------------------
  assign upd_o      = push;
  assign upd_addr_o = st_addr_i;
  assign upd_idx_o  = tail_q;

  assign lk_addr    = q_addr[lk_idx_i];
  assign lk_live_o  = q_live[lk_idx_i];
  assign lk_width_o = q_width[lk_idx_i];
  // same tag layout as the cache, upper bits and byte offset
  assign lk_tag_o   = {lk_addr[XLEN-1:2+StIdxW], lk_addr[1:0]};
  assign lk_value_o = q_value[lk_idx_i];

  // ------------------------------------------------------------
  // drain, one write per head entry
  // ------------------------------------------------------------
  assign head_off = q_addr[head_q][1:0];
  // held steady until ack since head only moves on ack
  assign wb_cyc_o = !empty_o;
  assign wb_stb_o = !empty_o;
  assign wb_we_o  = 1'b1;
  assign wb_adr_o = {q_addr[head_q][XLEN-1:2], 2'b00};
  assign wb_sel_o = ldst_sel(q_width[head_q], head_off);
  // move the right-aligned value onto its lanes
  assign wb_dat_o = q_value[head_q] << {head_off, 3'b000};

endmodule

//--- rtl/fwd_cache.sv
`timescale 1ns/1ps

module fwd_cache import ldst_pkg::*; #(
  parameter int unsigned STBUFF_DEPTH = 4,
  localparam int unsigned StIdxW = $clog2(STBUFF_DEPTH),
  localparam int unsigned TagW = XLEN - StIdxW
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  // store side update
  input  logic              upd_i,
  input  logic [XLEN-1:0]   upd_addr_i,
  input  logic [StIdxW-1:0] upd_idx_i,
  // load side lookup
  input  logic [XLEN-1:0]   ld_addr_i,
  input  ldst_width_t       ld_width_i,
  // entry named by the slot, as seen in the store buffer
  input  logic              ent_live_i,
  input  ldst_width_t       ent_width_i,
  input  logic [TagW-1:0]   ent_tag_i,
  input  logic [XLEN-1:0]   ent_value_i,
  output logic [StIdxW-1:0] ent_idx_o,
  output logic              hit_o,
  output logic [XLEN-1:0]   value_o
);

  // ------------------------------------------------------------
  // slot table
  // ------------------------------------------------------------
  logic              slot_valid [STBUFF_DEPTH];
  logic [TagW-1:0]   slot_tag   [STBUFF_DEPTH];
  logic [StIdxW-1:0] slot_idx   [STBUFF_DEPTH];

  // slot select sits just above the byte offset
  logic [StIdxW-1:0] upd_slot;
  logic [TagW-1:0]   upd_tag;
  logic [StIdxW-1:0] ld_slot;
  logic [TagW-1:0]   ld_tag;
  logic              upd_en;
  logic              slot_hit;
  logic              ent_hit;

  assign upd_slot = upd_addr_i[2 +: StIdxW];
  // tag keeps the upper bits plus the byte offset
  assign upd_tag  = {upd_addr_i[XLEN-1:2+StIdxW], upd_addr_i[1:0]};
  assign ld_slot  = ld_addr_i[2 +: StIdxW];
  assign ld_tag   = {ld_addr_i[XLEN-1:2+StIdxW], ld_addr_i[1:0]};

  // reserved low region never recorded
  assign upd_en = upd_i && ((upd_addr_i & FWD_MASK) != '0);

  // valid bits, flush wins over an update
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < STBUFF_DEPTH; i++) slot_valid[i] <= 1'b0;
    end else if (flush_i) begin
      for (int i = 0; i < STBUFF_DEPTH; i++) slot_valid[i] <= 1'b0;
    end else if (upd_en) begin
      slot_valid[upd_slot] <= 1'b1;
    end
  end

  // tag and entry index payload
  always_ff @(posedge clk_i) begin
    if (upd_en) begin
      slot_tag[upd_slot] <= upd_tag;
      slot_idx[upd_slot] <= upd_idx_i;
    end
  end

  // ------------------------------------------------------------
  // hit decision
  // ------------------------------------------------------------
  assign ent_idx_o = slot_idx[ld_slot];
  assign slot_hit  = slot_valid[ld_slot] && (slot_tag[ld_slot] == ld_tag);
  // entry must still be buffered, same width and same address
  assign ent_hit   = ent_live_i && (ent_width_i == ld_width_i) && (ent_tag_i == ld_tag);
  assign hit_o     = slot_hit && ent_hit;
  // stored value is right-aligned, trim to the load width
  assign value_o   = ldst_zext(ld_width_i, ent_value_i);

endmodule

//--- common/ldst_pkg.sv
package ldst_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  // data and address width
  localparam int unsigned XLEN = 32;
  // byte select width of the bus
  localparam int unsigned WB_SEL_W = XLEN / 8;

  // access width of a load or a store
  typedef enum logic [1:0] {
    LDST_BYTE = 2'd0,
    LDST_HALF = 2'd1,
    LDST_WORD = 2'd2
  } ldst_width_t;

  // stores with no bit set under this mask sit in the reserved low region
  localparam logic [XLEN-1:0] FWD_MASK = 32'hffff_ff00;

  // ------------------------------------------------------------
  // bus select helpers
  // ------------------------------------------------------------
  // byte lanes touched by an access of width w at byte offset off
  function automatic logic [WB_SEL_W-1:0] ldst_sel(ldst_width_t w, logic [1:0] off);
    logic [WB_SEL_W-1:0] base;
    case (w)
      LDST_BYTE: base = 4'b0001;
      LDST_HALF: base = 4'b0011;
      default:   base = 4'b1111;
    endcase
    return base << off;
  endfunction

  // keep only the low lanes of a right-aligned value, zero above
  function automatic logic [XLEN-1:0] ldst_zext(ldst_width_t w, logic [XLEN-1:0] v);
    case (w)
      LDST_BYTE: return {{(XLEN-8){1'b0}}, v[7:0]};
      LDST_HALF: return {{(XLEN-16){1'b0}}, v[15:0]};
      default:   return v;
    endcase
  endfunction

endpackage
